// ==== Makefile ====
# Verilator build for the iterative multiplier testbench

VERILATOR ?= verilator
TOP       ?= imul_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/imul_ctrl.sv ====
// ----------------------------
// multiplier control FSM
// handshake, iteration count and datapath strobes
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_ctrl (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req_val,
  output logic                       req_rdy,
  output logic                       resp_val,
  input  wire                        resp_rdy,
  output imul_pkg::imul_dpath_ctrl_t dpath_ctrl
);

  import imul_pkg::*;

  // count value on the final step
  localparam logic [`IMUL_COUNT_BITS-1:0] last_count = `IMUL_COUNT_BITS'(`IMUL_WIDTH - 1);

  imul_state_e                 state;
  logic [`IMUL_COUNT_BITS-1:0] count;

  // transfers on either side
  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------
  // state and counter
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          // operands load on this same edge
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // one step per cycle, the 32nd step ends the run
          if (count == last_count) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold until the response is taken
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // ----------------------------
  // outputs
  // ----------------------------

  // Moore outputs, except load which follows req_val in IDLE
  always_comb begin
    req_rdy         = 1'b0;
    resp_val        = 1'b0;
    dpath_ctrl.load = 1'b0;
    dpath_ctrl.step = 1'b0;
    case (state)
      IDLE: begin
        req_rdy         = 1'b1;
        dpath_ctrl.load = req_val;
      end
      CALC: begin
        dpath_ctrl.step = 1'b1;
      end
      DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/imul_iterative.sv ====
// ----------------------------
// 32-bit signed iterative multiplier
// val/rdy request in, 64-bit product out
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_iterative (
  input  wire                      clk,
  input  wire                      reset,
  input  wire imul_pkg::imul_req_t req_msg,
  input  wire                      req_val,
  output logic                     req_rdy,
  output imul_pkg::imul_resp_t     resp_msg,
  output logic                     resp_val,
  input  wire                      resp_rdy
);

  import imul_pkg::*;

  // strobes shared by sign unit and datapath
  imul_dpath_ctrl_t           dpath_ctrl;
  logic [`IMUL_WIDTH-1:0]     a_mag;
  logic [`IMUL_WIDTH-1:0]     b_mag;
  logic [2*`IMUL_WIDTH-1:0]   product_mag;

  // FSM, never sees the data
  imul_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .dpath_ctrl (dpath_ctrl)
  );

  // magnitudes in, signed result out
  imul_sign_unit sign (
    .clk         (clk),
    .reset       (reset),
    .req_msg     (req_msg),
    .dpath_ctrl  (dpath_ctrl),
    .a_mag       (a_mag),
    .b_mag       (b_mag),
    .product_mag (product_mag),
    .resp_msg    (resp_msg)
  );

  // unsigned shift-and-add core
  imul_shift_add_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .dpath_ctrl  (dpath_ctrl),
    .a_mag       (a_mag),
    .b_mag       (b_mag),
    .product_mag (product_mag)
  );

endmodule

`default_nettype wire

// ==== source/imul_params.svh ====
// ----------------------------
// iterative multiplier sizing
// operand width and iteration counter width
// ----------------------------
`ifndef IMUL_PARAMS_SVH
`define IMUL_PARAMS_SVH

// operand width in bits, the product is twice as wide
`define IMUL_WIDTH 32

// wide enough to count 0 to IMUL_WIDTH-1
`define IMUL_COUNT_BITS 6

`endif

// ==== source/imul_pkg.sv ====
// ----------------------------
// iterative multiplier types
// message structs, datapath strobes and FSM states
// ----------------------------
`default_nettype none

`include "imul_params.svh"

package imul_pkg;

  // ----------------------------
  // messages
  // ----------------------------

  // request carries two signed operands
  typedef struct packed {
    logic [`IMUL_WIDTH-1:0] a;
    logic [`IMUL_WIDTH-1:0] b;
  } imul_req_t;

  // response carries the full signed product
  typedef struct packed {
    logic [2*`IMUL_WIDTH-1:0] result;
  } imul_resp_t;

  // ----------------------------
  // control
  // ----------------------------

  // strobes from the FSM to the datapath blocks
  // load only on the accepting cycle, step once per CALC cycle
  typedef struct packed {
    logic load;
    logic step;
  } imul_dpath_ctrl_t;

  // FSM states
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } imul_state_e;

endpackage

`default_nettype wire

// ==== source/imul_shift_add_dpath.sv ====
// ----------------------------
// shift-and-add datapath
// one conditional add and shift per step
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_shift_add_dpath (
  input  wire                             clk,
  input  wire                             reset,
  input  wire imul_pkg::imul_dpath_ctrl_t dpath_ctrl,
  input  wire  [`IMUL_WIDTH-1:0]          a_mag,
  input  wire  [`IMUL_WIDTH-1:0]          b_mag,
  output logic [2*`IMUL_WIDTH-1:0]        product_mag
);

  // ----------------------------
  // state
  // ----------------------------

  // multiplicand moves left, so it needs the full product width
  logic [2*`IMUL_WIDTH-1:0] mcand;
  // multiplier moves right, bit 0 picks the add
  logic [`IMUL_WIDTH-1:0]   mplier;
  // running partial product
  logic [2*`IMUL_WIDTH-1:0] acc;

  // ----------------------------
  // next values
  // ----------------------------

  logic [2*`IMUL_WIDTH-1:0] mcand_shift;
  logic [`IMUL_WIDTH-1:0]   mplier_shift;
  logic [2*`IMUL_WIDTH-1:0] acc_sum;

  assign mcand_shift  = mcand << 1;
  assign mplier_shift = mplier >> 1;
  // magnitudes below 2^W keep the sum inside 2W bits
  assign acc_sum      = acc + mcand;

  // ----------------------------
  // registers
  // ----------------------------

  // operand registers
  always_ff @(posedge clk) begin
    if (reset) begin
      mcand  <= '0;
      mplier <= '0;
    end else if (dpath_ctrl.load) begin
      // zero-extend the multiplicand into the upper half
      mcand  <= {{`IMUL_WIDTH{1'b0}}, a_mag};
      mplier <= b_mag;
    end else if (dpath_ctrl.step) begin
      mcand  <= mcand_shift;
      mplier <= mplier_shift;
    end
  end

  // accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (dpath_ctrl.load) begin
      acc <= '0;
    end else if (dpath_ctrl.step && mplier[0]) begin
      // add only when the current multiplier bit is one
      acc <= acc_sum;
    end
  end

  // product is the accumulator itself, held through DONE
  assign product_mag = acc;

endmodule

`default_nettype wire

// ==== source/imul_sign_unit.sv ====
// ----------------------------
// sign handling for the multiplier
// magnitudes in, sign register, negated product out
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_sign_unit (
  input  wire                           clk,
  input  wire                           reset,
  input  wire imul_pkg::imul_req_t      req_msg,
  input  wire imul_pkg::imul_dpath_ctrl_t dpath_ctrl,
  output logic [`IMUL_WIDTH-1:0]        a_mag,
  output logic [`IMUL_WIDTH-1:0]        b_mag,
  input  wire  [2*`IMUL_WIDTH-1:0]      product_mag,
  output imul_pkg::imul_resp_t          resp_msg
);

  // set when exactly one operand is negative
  logic result_neg;

  // two's complement magnitudes, straight from the request
  // most negative input maps to 2^(W-1), still fits unsigned
  assign a_mag = req_msg.a[`IMUL_WIDTH-1] ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag = req_msg.b[`IMUL_WIDTH-1] ? (~req_msg.b + 1'b1) : req_msg.b;

  // capture the result sign with the operands
  always_ff @(posedge clk) begin
    if (reset) begin
      result_neg <= 1'b0;
    end else if (dpath_ctrl.load) begin
      result_neg <= req_msg.a[`IMUL_WIDTH-1] ^ req_msg.b[`IMUL_WIDTH-1];
    end
  end

  // final conditional negation of the unsigned product
  assign resp_msg.result = result_neg ? (~product_mag + 1'b1) : product_mag;

endmodule

`default_nettype wire

// ==== test/imul_props.sv ====
// ----------------------------
// handshake and timing assertions
// bound into the multiplier top level
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_props (
  input wire                       clk,
  input wire                       reset,
  input wire                       req_val,
  input wire                       req_rdy,
  input wire                       resp_val,
  input wire                       resp_rdy,
  input wire imul_pkg::imul_resp_t resp_msg
);

  // edges since the last accept, saturates while idle
  logic [`IMUL_COUNT_BITS-1:0] since_accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_accept <= '0;
    end else if (req_val && req_rdy) begin
      since_accept <= '0;
    end else if (!resp_val && since_accept != '1) begin
      since_accept <= since_accept + 1'b1;
    end
  end

  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // response held and stable under back-pressure
  resp_held: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else $error("response changed while stalled");

  resp_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> since_accept == `IMUL_COUNT_BITS'(`IMUL_WIDTH))
    else $error("response did not rise 32 cycles after accept");

  resp_quiet_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high right after reset");

endmodule

bind imul_iterative imul_props props (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp_msg (resp_msg)
);

`default_nettype wire

// ==== test/imul_tb.sv ====
// ----------------------------
// testbench for the iterative multiplier
// random and corner operands against a signed product model
// ----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "imul_params.svh"

module imul_tb;

  import imul_pkg::*;

  // ----------------------------
  // test sizing
  // ----------------------------
  localparam int num_random  = 300;
  localparam int num_corner  = 25;
  localparam int num_stream  = 20;
  localparam int num_reqs    = num_random + num_corner + num_stream;
  localparam int max_stall   = 8;
  localparam int max_gap     = 3;
  // accept wait, 33 edges to response, stall, transfer and gap per request
  localparam int cycle_limit = num_reqs * (`IMUL_WIDTH + 3 + max_stall + max_gap) + 200;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  imul_req_t  req_msg = '0;
  logic       req_val = 1'b0;
  logic       req_rdy;
  imul_resp_t resp_msg;
  logic       resp_val;
  logic       resp_rdy = 1'b0;

  // single-entry holding register for the expected product
  logic [2*`IMUL_WIDTH-1:0] exp_result = '0;
  bit exp_full      = 1'b0;
  int cycles        = 0;
  int accept_cycle  = 0;
  int resp_count    = 0;
  bit prev_resp_val = 1'b0;
  bit prev_resp_rdy = 1'b0;
  bit prev_resp_go  = 1'b0;

  imul_iterative dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    forever begin
      #5 clk = ~clk;
    end
  end

  // ----------------------------
  // model and helpers
  // ----------------------------

  // reference product of the operands sign-extended to 64 bits
  function automatic logic [2*`IMUL_WIDTH-1:0] signed_product(input logic [`IMUL_WIDTH-1:0] a,
                                                              input logic [`IMUL_WIDTH-1:0] b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    return 64'(sa * sb);
  endfunction

  // a quarter of the draws are small signed values
  function automatic logic [`IMUL_WIDTH-1:0] random_operand();
    logic [`IMUL_WIDTH-1:0] r;
    r = $urandom;
    if (r[1:0] == 2'b00) begin
      return {{24{r[31]}}, r[31:24]};
    end
    return $urandom;
  endfunction

  task automatic expect_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
    if (actual !== expected) begin
      $display("** Error at %0.1f ns: %s, got %h, expected %h", $realtime, what, actual,
               expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // ----------------------------
  // monitor sampled on the rising edge
  // ----------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run passed %0d cycles with %0d of %0d responses", cycle_limit,
               resp_count, num_reqs);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
    if (!reset) begin
      expect_equal(64'(req_rdy && resp_val), 64'd0, "req_rdy and resp_val both high");
      // busy from accept until the response is taken
      if (exp_full) begin
        expect_equal(64'(req_rdy), 64'd0, "req_rdy high while busy");
      end
      if (prev_resp_go) begin
        expect_equal(64'(resp_val), 64'd0, "resp_val after response transfer");
        expect_equal(64'(req_rdy), 64'd1, "req_rdy after response transfer");
      end
      // back-pressure holds the response
      if (prev_resp_val && !prev_resp_rdy) begin
        expect_equal(64'(resp_val), 64'd1, "resp_val dropped under back-pressure");
      end
      if (resp_val) begin
        expect_equal(64'(exp_full), 64'd1, "response with no request in flight");
        // rose right after E32 so first seen at the 33rd edge
        if (!prev_resp_val) begin
          expect_equal(64'(cycles - accept_cycle), 64'(`IMUL_WIDTH + 1), "response latency");
        end
        expect_equal(resp_msg.result, exp_result, "product");
      end
      if (resp_val && resp_rdy) begin
        exp_full   = 1'b0;
        resp_count = resp_count + 1;
      end
      if (req_val && req_rdy) begin
        exp_result   = signed_product(req_msg.a, req_msg.b);
        exp_full     = 1'b1;
        accept_cycle = cycles;
      end
    end
    prev_resp_val = resp_val;
    prev_resp_rdy = resp_rdy;
    prev_resp_go  = resp_val && resp_rdy && !reset;
  end

  // ----------------------------
  // stimulus tasks start and end 1 ns after an edge
  // ----------------------------

  // one multiply with a random response stall and idle gap
  task automatic run_mul(input logic [`IMUL_WIDTH-1:0] a, input logic [`IMUL_WIDTH-1:0] b);
    int stall;
    int gap;
    stall     = int'($urandom_range(max_stall, 0));
    gap       = int'($urandom_range(max_gap, 0));
    req_msg.a = a;
    req_msg.b = b;
    req_val   = 1'b1;
    resp_rdy  = (stall == 0);
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    #1;
    // junk on the request side must not be accepted while busy
    req_msg.a = $urandom;
    req_msg.b = $urandom;
    req_val   = 1'($urandom_range(1, 0));
    @(posedge clk);
    while (!resp_val) @(posedge clk);
    if (stall > 0) begin
      repeat (stall - 1) @(posedge clk);
      #1;
      resp_rdy = 1'b1;
      @(posedge clk);
    end
    #1;
    resp_rdy = 1'b0;
    req_val  = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // back-to-back requests with req_val and resp_rdy held high
  task automatic run_stream(input int count);
    int i;
    req_val  = 1'b1;
    resp_rdy = 1'b1;
    for (i = 0; i < count; i++) begin
      req_msg.a = random_operand();
      req_msg.b = random_operand();
      @(posedge clk);
      while (!req_rdy) @(posedge clk);
      #1;
    end
    req_val = 1'b0;
    @(posedge clk);
    while (!resp_val) @(posedge clk);
    #1;
    resp_rdy = 1'b0;
  endtask

  initial begin
    logic [`IMUL_WIDTH-1:0] corners [5];
    int i;
    int j;
    corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
    void'($urandom(32'he0d2));
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    expect_equal(64'(req_rdy), 64'd1, "req_rdy after reset");
    expect_equal(64'(resp_val), 64'd0, "resp_val after reset");
    for (i = 0; i < num_random; i++) begin
      run_mul(random_operand(), random_operand());
    end
    // every pairing of the corner values
    for (i = 0; i < 5; i++) begin
      for (j = 0; j < 5; j++) begin
        run_mul(corners[i], corners[j]);
      end
    end
    run_stream(num_stream);
    if (resp_count == num_reqs && !exp_full) begin
      $display("Test completed successfully");
    end else begin
      $display("run ended with %0d of %0d responses taken", resp_count, num_reqs);
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/imul_pkg.sv
source/imul_sign_unit.sv
source/imul_shift_add_dpath.sv
source/imul_ctrl.sv
source/imul_iterative.sv
test/imul_props.sv
test/imul_tb.sv
